// File: aes_ctrl_pkg.sv
`default_nettype none

package aes_ctrl_pkg;

	// ========================================
	// Widths and depths

	localparam int word_w        = 32;
	localparam int blk_w         = 128;
	localparam int key_w         = 256;
	localparam int words_per_blk = 4;

	// Block plus the last flag on top
	localparam int entry_w       = blk_w + 1;

	localparam int fifo_depth    = 16;
	localparam int fifo_aw       = 4;

	// ========================================
	// Command field codes

	localparam logic       op_encrypt = 1'b0;
	localparam logic       op_decrypt = 1'b1;

	localparam logic       ksz_128    = 1'b0;
	localparam logic       ksz_256    = 1'b1;

	localparam logic [2:0] mode_ecb   = 3'd0;
	localparam logic [2:0] mode_cbc   = 3'd1;

	// Mode engine FSM states
	localparam logic [1:0] eng_cmd     = 2'd0;
	localparam logic [1:0] eng_key1    = 2'd1;
	localparam logic [1:0] eng_key2    = 2'd2;
	localparam logic [1:0] eng_payload = 2'd3;

	// Command word layout, operation in bit 0
	typedef struct packed {
		logic [26:0] reserved;
		logic [2:0]  mode;
		logic        key_size;
		logic        op;
	} cmd_fields_t;

	typedef union packed {
		logic [word_w-1:0] raw;
		cmd_fields_t       fields;
	} cmd_word_u;

endpackage

`default_nettype wire

// File: logic/block_packer.sv
`timescale 1ns/1ps
`default_nettype none

module block_packer (
	input  wire                                 clk,
	input  wire                                 reset,

	input  wire                                 in_bus_data_wren,
	input  wire                                 in_bus_tlast,
	input  wire  [aes_ctrl_pkg::word_w-1:0]     in_bus_data,
	output logic                                controller_in_busy,

	output logic                                wr_valid,
	output logic [aes_ctrl_pkg::entry_w-1:0]    wr_data,
	input  wire                                 wr_ready
);

	logic [$clog2(aes_ctrl_pkg::words_per_blk)-1:0] word_idx;
	logic [aes_ctrl_pkg::blk_w-1:0]                 asm_data;
	logic [aes_ctrl_pkg::blk_w-1:0]                 asm_next;
	logic                                           close_entry;

	// Fourth word or an early tlast closes the entry
	assign close_entry = in_bus_data_wren &&
		(in_bus_tlast || word_idx == aes_ctrl_pkg::words_per_blk - 1);

	// Held entry or full FIFO blocks the sender
	assign controller_in_busy = wr_valid || !wr_ready;

	// ========================================
	// Assembly

	// Earlier words kept, new word in its slot, words above it zero
	always_comb begin
		for (int i = 0; i < aes_ctrl_pkg::words_per_blk; i++) begin
			if (i < word_idx) begin
				asm_next[i*aes_ctrl_pkg::word_w +: aes_ctrl_pkg::word_w] =
					asm_data[i*aes_ctrl_pkg::word_w +: aes_ctrl_pkg::word_w];
			end else if (i == word_idx) begin
				asm_next[i*aes_ctrl_pkg::word_w +: aes_ctrl_pkg::word_w] = in_bus_data;
			end else begin
				asm_next[i*aes_ctrl_pkg::word_w +: aes_ctrl_pkg::word_w] = '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_bus_data_wren) begin
			asm_data <= asm_next;
		end
		if (close_entry) begin
			wr_data <= {in_bus_tlast, asm_next};
		end
	end

	// ========================================
	// Word index and hand-off

	always_ff @(posedge clk) begin
		if (reset) begin
			word_idx <= '0;
			wr_valid <= 1'b0;
		end else begin
			if (wr_valid && wr_ready) begin
				wr_valid <= 1'b0;
			end
			if (close_entry) begin
				word_idx <= '0;
				wr_valid <= 1'b1;
			end else if (in_bus_data_wren) begin
				word_idx <= word_idx + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/block_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module block_fifo (
	input  wire                                 clk,
	input  wire                                 reset,

	input  wire                                 wr_valid,
	input  wire  [aes_ctrl_pkg::entry_w-1:0]    wr_data,
	output logic                                wr_ready,

	output logic                                rd_valid,
	output logic [aes_ctrl_pkg::entry_w-1:0]    rd_data,
	input  wire                                 rd_ready
);

	logic [aes_ctrl_pkg::entry_w-1:0] mem [aes_ctrl_pkg::fifo_depth];

	logic [aes_ctrl_pkg::fifo_aw-1:0] wr_ptr;
	logic [aes_ctrl_pkg::fifo_aw-1:0] rd_ptr;
	logic [aes_ctrl_pkg::fifo_aw:0]   count;

	logic                             wr_en;
	logic                             rd_en;

	assign wr_ready = (count != aes_ctrl_pkg::fifo_depth);
	assign rd_valid = (count != 0);

	assign wr_en = wr_valid && wr_ready;
	assign rd_en = rd_valid && rd_ready;

	// Head entry visible without a read cycle
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// ========================================
	// Pointers and fill count

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (wr_en && !rd_en) begin
				count <= count + 1'b1;
			end else if (rd_en && !wr_en) begin
				count <= count - 1'b1;
			end
		end
	end

	// ========================================
	// Checks

	// Never past full
	assert property (@(posedge clk) disable iff (reset)
		count <= aes_ctrl_pkg::fifo_depth);

	// Pointer distance keeps up with the count over every write and read
	assert property (@(posedge clk) disable iff (reset)
		count[aes_ctrl_pkg::fifo_aw-1:0] == wr_ptr - rd_ptr);

endmodule

`default_nettype wire

// File: logic/mode_engine.sv
`timescale 1ns/1ps
`default_nettype none

module mode_engine (
	input  wire                                 clk,
	input  wire                                 reset,

	input  wire                                 in_valid,
	input  wire  [aes_ctrl_pkg::entry_w-1:0]    in_data,
	output logic                                in_ready,

	output logic                                out_valid,
	output logic [aes_ctrl_pkg::entry_w-1:0]    out_data,
	input  wire                                 out_ready
);

	logic [1:0]                       state;
	aes_ctrl_pkg::cmd_word_u          cmd;
	logic                             iv_pending;

	logic [aes_ctrl_pkg::key_w-1:0]   key_reg;
	logic [aes_ctrl_pkg::blk_w-1:0]   work_key;
	logic [aes_ctrl_pkg::blk_w-1:0]   chain;
	logic [aes_ctrl_pkg::blk_w-1:0]   chain_next;

	logic [aes_ctrl_pkg::blk_w-1:0]   in_blk;
	logic                             in_last;
	logic [aes_ctrl_pkg::blk_w-1:0]   res_blk;
	logic                             emit;

	logic                             rd_en;
	logic                             take_payload;

	assign in_blk  = in_data[aes_ctrl_pkg::blk_w-1:0];
	assign in_last = in_data[aes_ctrl_pkg::blk_w];

	// Command and keys always accepted
	// Payload only when the result slot frees up this cycle
	assign in_ready = (state == aes_ctrl_pkg::eng_payload) ? (!out_valid || out_ready) : 1'b1;

	assign rd_en        = in_valid && in_ready;
	assign take_payload = rd_en && (state == aes_ctrl_pkg::eng_payload);

	// Whitening key from both halves
	assign work_key = key_reg[aes_ctrl_pkg::key_w-1:aes_ctrl_pkg::blk_w] ^
		key_reg[aes_ctrl_pkg::blk_w-1:0];

	// ========================================
	// Block transform

	always_comb begin
		emit       = 1'b0;
		res_blk    = in_blk ^ work_key;
		chain_next = chain;
		case (cmd.fields.mode)
			aes_ctrl_pkg::mode_ecb: begin
				emit = 1'b1;
			end
			aes_ctrl_pkg::mode_cbc: begin
				if (iv_pending) begin
					// IV only seeds the chain
					chain_next = in_blk;
				end else begin
					emit    = 1'b1;
					res_blk = in_blk ^ chain ^ work_key;
					// Chain always follows the ciphertext side
					if (cmd.fields.op == aes_ctrl_pkg::op_encrypt) begin
						chain_next = res_blk;
					end else begin
						chain_next = in_blk;
					end
				end
			end
			default: begin
				// Unsupported mode, payload is dropped
				emit = 1'b0;
			end
		endcase
	end

	// ========================================
	// Control FSM

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= aes_ctrl_pkg::eng_cmd;
			cmd.raw    <= '0;
			iv_pending <= 1'b0;
			out_valid  <= 1'b0;
		end else begin
			if (out_valid && out_ready) begin
				out_valid <= 1'b0;
			end
			if (take_payload && emit) begin
				out_valid <= 1'b1;
			end

			case (state)
				aes_ctrl_pkg::eng_cmd: begin
					if (rd_en) begin
						cmd.raw    <= in_data[aes_ctrl_pkg::word_w-1:0];
						iv_pending <= 1'b1;
						state      <= aes_ctrl_pkg::eng_key1;
					end
				end
				aes_ctrl_pkg::eng_key1: begin
					if (rd_en) begin
						if (cmd.fields.key_size == aes_ctrl_pkg::ksz_256) begin
							state <= aes_ctrl_pkg::eng_key2;
						end else begin
							state <= aes_ctrl_pkg::eng_payload;
						end
					end
				end
				aes_ctrl_pkg::eng_key2: begin
					if (rd_en) begin
						state <= aes_ctrl_pkg::eng_payload;
					end
				end
				default: begin
					if (take_payload) begin
						iv_pending <= 1'b0;
						if (in_last) begin
							state <= aes_ctrl_pkg::eng_cmd;
						end
					end
				end
			endcase
		end
	end

	// ========================================
	// Key, chain and result registers

	always_ff @(posedge clk) begin
		if (rd_en && state == aes_ctrl_pkg::eng_key1) begin
			key_reg[aes_ctrl_pkg::key_w-1:aes_ctrl_pkg::blk_w] <= in_blk;
			// Lower half stays zero for a 128-bit key
			key_reg[aes_ctrl_pkg::blk_w-1:0] <= '0;
		end
		if (rd_en && state == aes_ctrl_pkg::eng_key2) begin
			key_reg[aes_ctrl_pkg::blk_w-1:0] <= in_blk;
		end
		if (take_payload) begin
			chain <= chain_next;
			if (emit) begin
				out_data <= {in_last, res_blk};
			end
		end
	end

	// Result held steady while the output FIFO stalls
	assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// File: logic/word_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module word_serializer (
	input  wire                                 clk,
	input  wire                                 reset,

	input  wire                                 in_valid,
	input  wire  [aes_ctrl_pkg::entry_w-1:0]    in_data,
	output logic                                in_ready,

	output logic                                out_bus_tvalid,
	input  wire                                 out_bus_tready,
	output logic [aes_ctrl_pkg::word_w-1:0]     out_bus_tdata,
	output logic                                out_bus_tlast
);

	logic [aes_ctrl_pkg::entry_w-1:0]               cur_entry;
	logic [$clog2(aes_ctrl_pkg::words_per_blk)-1:0] word_idx;
	logic                                           last_word;

	assign last_word = (word_idx == aes_ctrl_pkg::words_per_blk - 1);

	// Next entry loads as the final word leaves
	assign in_ready = !out_bus_tvalid || (out_bus_tready && last_word);

	// Low word goes out first
	assign out_bus_tdata = cur_entry[word_idx*aes_ctrl_pkg::word_w +: aes_ctrl_pkg::word_w];
	assign out_bus_tlast = cur_entry[aes_ctrl_pkg::blk_w] && last_word;

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			cur_entry <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_bus_tvalid <= 1'b0;
			word_idx       <= '0;
		end else begin
			if (in_valid && in_ready) begin
				out_bus_tvalid <= 1'b1;
				word_idx       <= '0;
			end else if (out_bus_tvalid && out_bus_tready) begin
				if (last_word) begin
					out_bus_tvalid <= 1'b0;
				end
				word_idx <= word_idx + 1'b1;
			end
		end
	end

	// Bus word and tlast frozen during a stall
	assert property (@(posedge clk) disable iff (reset)
		out_bus_tvalid && !out_bus_tready |=>
			out_bus_tvalid && $stable(out_bus_tdata) && $stable(out_bus_tlast));

endmodule

`default_nettype wire

// File: logic/aes_controller_top.sv
`timescale 1ns/1ps
`default_nettype none

module aes_controller_top (
	input  wire                                 clk,
	input  wire                                 reset,

	// Input bus
	input  wire                                 in_bus_data_wren,
	input  wire                                 in_bus_tlast,
	input  wire  [aes_ctrl_pkg::word_w-1:0]     in_bus_data,
	output logic                                controller_in_busy,

	// Output bus
	output logic                                out_bus_tvalid,
	input  wire                                 out_bus_tready,
	output logic [aes_ctrl_pkg::word_w-1:0]     out_bus_tdata,
	output logic                                out_bus_tlast
);

	wire                               in_fifo_wr_valid;
	wire                               in_fifo_wr_ready;
	wire [aes_ctrl_pkg::entry_w-1:0]   in_fifo_wr_data;
	wire                               in_fifo_rd_valid;
	wire                               in_fifo_rd_ready;
	wire [aes_ctrl_pkg::entry_w-1:0]   in_fifo_rd_data;

	wire                               out_fifo_wr_valid;
	wire                               out_fifo_wr_ready;
	wire [aes_ctrl_pkg::entry_w-1:0]   out_fifo_wr_data;
	wire                               out_fifo_rd_valid;
	wire                               out_fifo_rd_ready;
	wire [aes_ctrl_pkg::entry_w-1:0]   out_fifo_rd_data;

	// ========================================
	// Input stage

	block_packer packer_i (
		.clk                (clk),
		.reset              (reset),
		.in_bus_data_wren   (in_bus_data_wren),
		.in_bus_tlast       (in_bus_tlast),
		.in_bus_data        (in_bus_data),
		.controller_in_busy (controller_in_busy),
		.wr_valid           (in_fifo_wr_valid),
		.wr_data            (in_fifo_wr_data),
		.wr_ready           (in_fifo_wr_ready)
	);

	block_fifo in_fifo_i (
		.clk      (clk),
		.reset    (reset),
		.wr_valid (in_fifo_wr_valid),
		.wr_data  (in_fifo_wr_data),
		.wr_ready (in_fifo_wr_ready),
		.rd_valid (in_fifo_rd_valid),
		.rd_data  (in_fifo_rd_data),
		.rd_ready (in_fifo_rd_ready)
	);

	// ========================================
	// Processing and output stage

	mode_engine engine_i (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_fifo_rd_valid),
		.in_data   (in_fifo_rd_data),
		.in_ready  (in_fifo_rd_ready),
		.out_valid (out_fifo_wr_valid),
		.out_data  (out_fifo_wr_data),
		.out_ready (out_fifo_wr_ready)
	);

	block_fifo out_fifo_i (
		.clk      (clk),
		.reset    (reset),
		.wr_valid (out_fifo_wr_valid),
		.wr_data  (out_fifo_wr_data),
		.wr_ready (out_fifo_wr_ready),
		.rd_valid (out_fifo_rd_valid),
		.rd_data  (out_fifo_rd_data),
		.rd_ready (out_fifo_rd_ready)
	);

	word_serializer serializer_i (
		.clk            (clk),
		.reset          (reset),
		.in_valid       (out_fifo_rd_valid),
		.in_data        (out_fifo_rd_data),
		.in_ready       (out_fifo_rd_ready),
		.out_bus_tvalid (out_bus_tvalid),
		.out_bus_tready (out_bus_tready),
		.out_bus_tdata  (out_bus_tdata),
		.out_bus_tlast  (out_bus_tlast)
	);

endmodule

`default_nettype wire

// File: tb/aes_controller_tb.sv
`timescale 1ns/1ps
`default_nettype none

module aes_controller_tb;

	logic        clk;
	logic        reset;
	logic        in_bus_data_wren;
	logic        in_bus_tlast;
	logic [31:0] in_bus_data;
	logic        controller_in_busy;
	logic        out_bus_tvalid;
	logic        out_bus_tready;
	logic [31:0] out_bus_tdata;
	logic        out_bus_tlast;

	logic [15:0]  data_lfsr;
	logic [15:0]  stall_lfsr;
	logic [31:0]  stall_bits;
	int           ready_mode;

	// Payload blocks of the current message and their reference results
	logic [127:0] pay_blk   [0:31];
	logic [127:0] res_blk   [0:31];
	logic [31:0]  exp_data  [$];
	logic         exp_last  [$];

	int mismatches   = 0;
	int other_errors = 0;
	int checks       = 0;
	int words_sent   = 0;
	int cycle_count  = 0;
	int busy_run     = 0;
	int max_busy_run = 0;

	aes_controller_top dut_i (
		.clk                (clk),
		.reset              (reset),
		.in_bus_data_wren   (in_bus_data_wren),
		.in_bus_tlast       (in_bus_tlast),
		.in_bus_data        (in_bus_data),
		.controller_in_busy (controller_in_busy),
		.out_bus_tvalid     (out_bus_tvalid),
		.out_bus_tready     (out_bus_tready),
		.out_bus_tdata      (out_bus_tdata),
		.out_bus_tlast      (out_bus_tlast)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ========================================
	// Random source and reference model

	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	task automatic take_bits(inout logic [15:0] state, input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits[i] = state[0];
			state = lfsr_next(state);
		end
	endtask

	task automatic random_block(output logic [127:0] blk);
		logic [31:0] w;
		for (int i = 0; i < 4; i++) begin
			take_bits(data_lfsr, 32, w);
			blk[i*32 +: 32] = w;
		end
	endtask

	// Words above the tail of the final block are zero, as the packer fills them
	task automatic fill_payload(input int n_blk, input int tail_words);
		logic [127:0] blk;
		for (int b = 0; b < n_blk; b++) begin
			random_block(blk);
			pay_blk[b] = blk;
		end
		for (int w = tail_words; w < 4; w++) begin
			pay_blk[n_blk-1][w*32 +: 32] = '0;
		end
	endtask

	function automatic void apply_reference(input logic [2:0] mode, input logic op,
		input logic ksz, input logic [127:0] key1, input logic [127:0] key2, input int n_blk);
		logic [127:0] wk;
		logic [127:0] chain;
		logic [127:0] r;
		logic         emit;
		int           n_res;
		wk    = ksz ? (key1 ^ key2) : key1;
		chain = '0;
		n_res = 0;
		for (int b = 0; b < n_blk; b++) begin
			emit = 1'b0;
			if (mode == aes_ctrl_pkg::mode_ecb) begin
				r    = pay_blk[b] ^ wk;
				emit = 1'b1;
			end else if (mode == aes_ctrl_pkg::mode_cbc) begin
				if (b == 0) begin
					// IV seeds the chain only
					chain = pay_blk[b];
				end else if (op == aes_ctrl_pkg::op_encrypt) begin
					r     = (pay_blk[b] ^ chain) ^ wk;
					chain = r;
					emit  = 1'b1;
				end else begin
					r     = (pay_blk[b] ^ wk) ^ chain;
					chain = pay_blk[b];
					emit  = 1'b1;
				end
			end
			if (emit) begin
				res_blk[n_res] = r;
				n_res++;
				for (int w = 0; w < 4; w++) begin
					exp_data.push_back(r[w*32 +: 32]);
					exp_last.push_back((b == n_blk - 1) && (w == 3));
				end
			end
		end
	endfunction

	// ========================================
	// Bus driving

	task automatic send_word(input logic [31:0] data, input logic last);
		@(negedge clk);
		in_bus_data_wren = 1'b0;
		while (controller_in_busy) begin
			@(negedge clk);
		end
		in_bus_data_wren = 1'b1;
		in_bus_data      = data;
		in_bus_tlast     = last;
		words_sent++;
	endtask

	task automatic send_message(input logic [2:0] mode, input logic op, input logic ksz,
		input logic [127:0] key1, input logic [127:0] key2, input int n_blk, input int tail_words);
		int nw;
		apply_reference(mode, op, ksz, key1, key2, n_blk);
		// Command in word 0 of its own entry
		send_word({27'd0, mode, ksz, op}, 1'b0);
		for (int w = 1; w < 4; w++) begin
			send_word(32'd0, 1'b0);
		end
		for (int w = 0; w < 4; w++) begin
			send_word(key1[w*32 +: 32], 1'b0);
		end
		if (ksz) begin
			for (int w = 0; w < 4; w++) begin
				send_word(key2[w*32 +: 32], 1'b0);
			end
		end
		for (int b = 0; b < n_blk; b++) begin
			nw = (b == n_blk - 1) ? tail_words : 4;
			for (int w = 0; w < nw; w++) begin
				send_word(pay_blk[b][w*32 +: 32], (b == n_blk - 1) && (w == nw - 1));
			end
		end
		@(negedge clk);
		in_bus_data_wren = 1'b0;
		in_bus_tlast     = 1'b0;
	endtask

	// Sparse ready in mode 2 so the FIFOs fill up
	always @(negedge clk) begin
		case (ready_mode)
			1: begin
				take_bits(stall_lfsr, 1, stall_bits);
				out_bus_tready = stall_bits[0];
			end
			2: begin
				take_bits(stall_lfsr, 3, stall_bits);
				out_bus_tready = (stall_bits[2:0] == 3'd0);
			end
			default: out_bus_tready = 1'b1;
		endcase
	end

	always @(negedge clk) begin
		if (controller_in_busy) begin
			busy_run++;
		end else begin
			busy_run = 0;
		end
		if (busy_run > max_busy_run) begin
			max_busy_run = busy_run;
		end
	end

	// ========================================
	// Checking and run limit

	task automatic compare_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_counts();
		$display("Checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
			other_errors);
	endtask

	always @(posedge clk) begin
		if (!reset && out_bus_tvalid && out_bus_tready) begin
			if (exp_data.size() == 0) begin
				other_errors++;
				$display("Unexpected output word %h at %0t ns", out_bus_tdata, $time);
			end else begin
				compare_value("out_bus_tdata", out_bus_tdata, exp_data.pop_front());
				compare_value("out_bus_tlast", out_bus_tlast, exp_last.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > 40 * words_sent + 500) begin
			$display("Run stopped after %0d cycles, the DUT did not finish in time",
				cycle_count);
			report_counts();
			$display("Test FAILED");
			$finish;
		end
	end

	// ========================================
	// Test sequence

	initial begin
		logic [127:0] k1;
		logic [127:0] k2;
		int           idle_cycles;
		reset            = 1'b1;
		in_bus_data_wren = 1'b0;
		in_bus_tlast     = 1'b0;
		in_bus_data      = '0;
		out_bus_tready   = 1'b0;
		ready_mode       = 0;
		data_lfsr        = 16'd61;
		stall_lfsr       = 16'd61;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// ECB both ways, 128-bit key
		random_block(k1);
		k2 = '0;
		fill_payload(4, 4);
		send_message(aes_ctrl_pkg::mode_ecb, aes_ctrl_pkg::op_encrypt, aes_ctrl_pkg::ksz_128,
			k1, k2, 4, 4);
		fill_payload(3, 4);
		send_message(aes_ctrl_pkg::mode_ecb, aes_ctrl_pkg::op_decrypt, aes_ctrl_pkg::ksz_128,
			k1, k2, 3, 4);

		// CBC round trip, 256-bit key
		random_block(k1);
		random_block(k2);
		fill_payload(5, 4);
		send_message(aes_ctrl_pkg::mode_cbc, aes_ctrl_pkg::op_encrypt, aes_ctrl_pkg::ksz_256,
			k1, k2, 5, 4);
		for (int i = 1; i < 5; i++) begin
			pay_blk[i] = res_blk[i-1];
		end
		send_message(aes_ctrl_pkg::mode_cbc, aes_ctrl_pkg::op_decrypt, aes_ctrl_pkg::ksz_256,
			k1, k2, 5, 4);

		// Long CBC message under random stalls
		@(posedge clk);
		ready_mode = 1;
		random_block(k1);
		fill_payload(17, 4);
		send_message(aes_ctrl_pkg::mode_cbc, aes_ctrl_pkg::op_encrypt, aes_ctrl_pkg::ksz_128,
			k1, k2, 17, 4);

		// tlast mid-block
		fill_payload(3, 2);
		send_message(aes_ctrl_pkg::mode_ecb, aes_ctrl_pkg::op_encrypt, aes_ctrl_pkg::ksz_256,
			k1, k2, 3, 2);

		// Unsupported mode, then a normal ECB message
		fill_payload(3, 4);
		send_message(3'd5, aes_ctrl_pkg::op_encrypt, aes_ctrl_pkg::ksz_128, k1, k2, 3, 4);
		fill_payload(2, 1);
		send_message(aes_ctrl_pkg::mode_ecb, aes_ctrl_pkg::op_decrypt, aes_ctrl_pkg::ksz_128,
			k1, k2, 2, 1);

		// Back-to-back messages faster than the output drains
		@(posedge clk);
		ready_mode   = 2;
		max_busy_run = 0;
		fill_payload(14, 4);
		send_message(aes_ctrl_pkg::mode_ecb, aes_ctrl_pkg::op_encrypt, aes_ctrl_pkg::ksz_128,
			k1, k2, 14, 4);
		fill_payload(12, 4);
		send_message(aes_ctrl_pkg::mode_cbc, aes_ctrl_pkg::op_decrypt, aes_ctrl_pkg::ksz_256,
			k1, k2, 12, 4);
		fill_payload(14, 3);
		send_message(aes_ctrl_pkg::mode_ecb, aes_ctrl_pkg::op_encrypt, aes_ctrl_pkg::ksz_128,
			k1, k2, 14, 3);
		if (max_busy_run < 3) begin
			other_errors++;
			$display("Input busy never stayed high long enough to show a full input FIFO");
		end

		// Drain what is left
		@(posedge clk);
		ready_mode  = 0;
		idle_cycles = 0;
		while (exp_data.size() != 0 && idle_cycles < 300) begin
			@(negedge clk);
			if (out_bus_tvalid) begin
				idle_cycles = 0;
			end else begin
				idle_cycles++;
			end
		end
		repeat (20) @(negedge clk);
		if (exp_data.size() != 0) begin
			other_errors++;
			$display("Expected queue still holds %0d words that never came out",
				exp_data.size());
		end

		report_counts();
		if (mismatches + other_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
aes_ctrl_pkg.sv
logic/block_packer.sv
logic/block_fifo.sv
logic/mode_engine.sv
logic/word_serializer.sv
logic/aes_controller_top.sv
tb/aes_controller_tb.sv
